//--- hacd_pkg.sv
package hacd_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths and address map
   //////////////////////////////////////////////////////////////////////

   localparam int unsigned ADDR_W     = 40;                   // memory side address bits
   localparam int unsigned DATA_W     = 64;                   // one beat
   localparam int unsigned LINE_BYTES = 64;                   // cacheline stride

   localparam logic [ADDR_W-1:0] DRAM_BASE = 40'h00_8000_0000; // cpu view of dram start
   localparam logic [ADDR_W-1:0] TBL_BASE  = 40'h00_0010_0000; // table region in memory

   localparam int unsigned TBL_LINES = 16;                    // lines zeroed at init
   localparam int unsigned TBL_CNT_W = $clog2(TBL_LINES + 1); // counts 0..TBL_LINES

   localparam int unsigned OWN_DEPTH = 4;                     // outstanding reqs tracked
   localparam int unsigned OWN_PTR_W = $clog2(OWN_DEPTH);     // owner fifo index
   localparam int unsigned OWN_CNT_W = $clog2(OWN_DEPTH + 1); // owner fifo fill level

   //////////////////////////////////////////////////////////////////////
   // request / response packets
   //////////////////////////////////////////////////////////////////////

   // single beat request, 106 bits
   typedef struct packed {
      logic              valid;                               // request present
      logic              we;                                  // 1 write, 0 read
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;                               // ignored on reads
   } mem_req_t;

   // in-order response, 65 bits
   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] rdata;                               // write ack carries junk
   } mem_rsp_t;

   // main control unit states
   typedef enum logic [1:0] {
      CU_IDLE   = 2'd0,                                       // just out of reset
      CU_INIT   = 2'd1,                                       // table sweep running
      CU_ACTIVE = 2'd2,                                       // tables built, cpu allowed
      CU_BYPASS = 2'd3                                        // hawk inactive
   } cu_state_e;

endpackage

//--- hawk_cpu_stall.sv
`timescale 1ns/1ns

module hawk_cpu_stall import hacd_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  logic     uart_boot_en_i,                  // cpu addresses already physical
   input  logic     allow_access_i,                  // from control unit
   input  mem_req_t cpu_req_i,
   output logic     cpu_ready_o,
   output mem_req_t cpu_fwd_o,                       // towards memory mux
   input  logic     cpu_fwd_ready_i
);

   logic              hold_vld_q;                    // holding reg occupied
   mem_req_t          hold_q;                        // captured request, rebased
   logic              fwd_take;                      // mux accepts held request
   logic              capture;                       // cpu request accepted here
   logic [ADDR_W-1:0] cpu_addr;                      // rebased cpu address

   //////////////////////////////////////////////////////////////////////
   // address rebase
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      if (uart_boot_en_i) begin
         cpu_addr = cpu_req_i.addr;                  // uart boot, no offset
      end else begin
         cpu_addr = cpu_req_i.addr - DRAM_BASE;      // strip dram base
      end
   end

   //////////////////////////////////////////////////////////////////////
   // holding register
   //////////////////////////////////////////////////////////////////////

   assign fwd_take    = cpu_fwd_o.valid & cpu_fwd_ready_i;
   assign cpu_ready_o = ~hold_vld_q | fwd_take;      // empty, or draining this cycle
   assign capture     = cpu_req_i.valid & cpu_ready_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hold_vld_q <= 1'b0;
      end else if (capture) begin
         hold_vld_q <= 1'b1;                         // refill even on same-cycle drain
      end else if (fwd_take) begin
         hold_vld_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (capture) begin
         hold_q       <= cpu_req_i;
         hold_q.addr  <= cpu_addr;
         hold_q.valid <= 1'b1;
      end
   end

   // stall point, nothing reaches memory until access granted
   always_comb begin
      cpu_fwd_o       = hold_q;
      cpu_fwd_o.valid = hold_vld_q & allow_access_i;
   end

endmodule

//--- hawk_ctrl_unit.sv
`timescale 1ns/1ns

module hawk_ctrl_unit import hacd_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      hawk_sw_inactive_i,            // software switch
   input  logic      hawk_reg_inactive_i,           // register switch
   input  logic      init_done_i,                   // table sweep finished
   output logic      init_start_o,                  // one cycle kick to table writer
   output logic      allow_access_o,                // releases cpu stall
   output cu_state_e cu_state_o
);

   cu_state_e state_q;
   cu_state_e state_d;
   logic      hawk_inactive;                        // either switch set
   logic      init_start_q;

   assign hawk_inactive = hawk_sw_inactive_i | hawk_reg_inactive_i;

   //////////////////////////////////////////////////////////////////////
   // next state
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         CU_IDLE: begin
            if (hawk_inactive) begin
               state_d = CU_BYPASS;                 // skip table setup
            end else begin
               state_d = CU_INIT;
            end
         end
         CU_INIT: begin
            if (init_done_i) begin
               state_d = CU_ACTIVE;                 // tables ready
            end
         end
         default: begin
            state_d = state_q;                      // active and bypass are terminal
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q      <= CU_IDLE;
         init_start_q <= 1'b0;
      end else begin
         state_q      <= state_d;
         init_start_q <= (state_q == CU_IDLE) & ~hawk_inactive; // first cycle of init
      end
   end

   assign init_start_o   = init_start_q;
   assign allow_access_o = (state_q == CU_ACTIVE) | (state_q == CU_BYPASS);
   assign cu_state_o     = state_q;

endmodule

//--- hawk_tbl_init.sv
`timescale 1ns/1ns

module hawk_tbl_init import hacd_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  logic     init_start_i,                   // pulse from control unit
   input  logic     tbl_ready_i,                    // mux took the write
   input  logic     tbl_rsp_valid_i,                // write ack routed back
   output mem_req_t tbl_req_o,
   output logic     init_done_o                     // sticky once sweep acked
);

   logic                 busy_q;                    // sweep in progress
   logic                 done_q;
   logic [TBL_CNT_W-1:0] iss_cnt_q;                 // writes issued
   logic [TBL_CNT_W-1:0] rsp_cnt_q;                 // acks received
   logic                 iss_left;                  // more writes to send
   logic                 last_rsp;                  // final ack this cycle

   assign iss_left = busy_q & (iss_cnt_q != TBL_CNT_W'(TBL_LINES));
   assign last_rsp = tbl_rsp_valid_i & (rsp_cnt_q == TBL_CNT_W'(TBL_LINES - 1));

   //////////////////////////////////////////////////////////////////////
   // issue and response counters
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q    <= 1'b0;
         done_q    <= 1'b0;
         iss_cnt_q <= '0;
         rsp_cnt_q <= '0;
      end else if (init_start_i) begin
         busy_q    <= 1'b1;                         // fresh sweep
         done_q    <= 1'b0;
         iss_cnt_q <= '0;
         rsp_cnt_q <= '0;
      end else begin
         if (tbl_req_o.valid && tbl_ready_i) begin
            iss_cnt_q <= iss_cnt_q + 1'b1;          // next line
         end
         if (busy_q && tbl_rsp_valid_i) begin
            rsp_cnt_q <= rsp_cnt_q + 1'b1;
         end
         if (busy_q && last_rsp) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;                         // rises cycle after last ack
         end
      end
   end

   // zero line write, held while mux is not ready
   always_comb begin
      tbl_req_o.valid = iss_left;
      tbl_req_o.we    = 1'b1;
      tbl_req_o.addr  = TBL_BASE + ADDR_W'(iss_cnt_q) * ADDR_W'(LINE_BYTES);
      tbl_req_o.wdata = '0;
   end

   assign init_done_o = done_q;

endmodule

//--- hawk_mem_mux.sv
`timescale 1ns/1ns

module hawk_mem_mux import hacd_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  mem_req_t tbl_req_i,                      // master 0, table writer
   input  mem_req_t cpu_req_i,                      // master 1, stalled cpu
   output logic     tbl_ready_o,
   output logic     cpu_ready_o,
   output mem_req_t mem_req_o,                      // to memory controller
   input  logic     mem_ready_i,
   input  mem_rsp_t mem_rsp_i,                      // in-order responses
   output logic     tbl_rsp_valid_o,
   output mem_rsp_t cpu_rsp_o
);

   logic                 own_mem [OWN_DEPTH];       // 1 = table writer owns
   logic [OWN_PTR_W-1:0] wr_ptr_q;
   logic [OWN_PTR_W-1:0] rd_ptr_q;
   logic [OWN_CNT_W-1:0] cnt_q;                     // outstanding requests
   logic                 own_full;
   logic                 tbl_sel;                   // table writer granted
   logic                 push;                      // memory transfer
   logic                 pop;                       // response arrives
   logic                 own_head;                  // owner of oldest request

   //////////////////////////////////////////////////////////////////////
   // request path, fixed priority
   //////////////////////////////////////////////////////////////////////

   assign own_full = (cnt_q == OWN_CNT_W'(OWN_DEPTH));
   assign tbl_sel  = tbl_req_i.valid;               // table writer wins when valid

   always_comb begin
      mem_req_o       = tbl_sel ? tbl_req_i : cpu_req_i;
      mem_req_o.valid = (tbl_req_i.valid | cpu_req_i.valid) & ~own_full; // no untracked req
   end

   assign tbl_ready_o = tbl_sel & mem_ready_i & ~own_full;
   assign cpu_ready_o = ~tbl_sel & mem_ready_i & ~own_full;

   //////////////////////////////////////////////////////////////////////
   // owner fifo
   //////////////////////////////////////////////////////////////////////

   assign push = mem_req_o.valid & mem_ready_i;
   assign pop  = mem_rsp_i.valid;

   always_ff @(posedge clk_i) begin
      if (push) begin
         own_mem[wr_ptr_q] <= tbl_sel;              // remember who issued
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;            // depth is a power of two
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;                // both or neither
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // response steering
   //////////////////////////////////////////////////////////////////////

   assign own_head = own_mem[rd_ptr_q];

   assign tbl_rsp_valid_o = pop & own_head;         // ack back to table writer

   always_comb begin
      cpu_rsp_o.valid = pop & ~own_head;
      cpu_rsp_o.rdata = mem_rsp_i.rdata;
   end

endmodule

//--- hacd_core.sv
`timescale 1ns/1ns

module hacd_core import hacd_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      uart_boot_en_i,
   input  logic      hawk_sw_inactive_i,
   input  logic      hawk_reg_inactive_i,
   // cpu side
   input  mem_req_t  cpu_req_i,
   output logic      cpu_ready_o,
   output mem_rsp_t  cpu_rsp_o,
   // memory controller side
   output mem_req_t  mem_req_o,
   input  logic      mem_ready_i,
   input  mem_rsp_t  mem_rsp_i,
   // status
   output logic      init_done_o,
   output cu_state_e cu_state_o
);

   mem_req_t cpu_fwd;                               // released cpu request
   logic     cpu_fwd_ready;
   mem_req_t tbl_req;                               // zero line writes
   logic     tbl_ready;
   logic     tbl_rsp_valid;
   logic     init_start;
   logic     allow_access;

   //////////////////////////////////////////////////////////////////////
   // control and table setup
   //////////////////////////////////////////////////////////////////////

   hawk_ctrl_unit u_hawk_ctrl_unit (
      .clk_i               (clk_i),
      .rst_n_i             (rst_n_i),
      .hawk_sw_inactive_i  (hawk_sw_inactive_i),
      .hawk_reg_inactive_i (hawk_reg_inactive_i),
      .init_done_i         (init_done_o),           // same net as status output
      .init_start_o        (init_start),
      .allow_access_o      (allow_access),
      .cu_state_o          (cu_state_o)
   );

   hawk_tbl_init u_hawk_tbl_init (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .init_start_i    (init_start),
      .tbl_ready_i     (tbl_ready),
      .tbl_rsp_valid_i (tbl_rsp_valid),
      .tbl_req_o       (tbl_req),
      .init_done_o     (init_done_o)
   );

   //////////////////////////////////////////////////////////////////////
   // cpu stall and memory port sharing
   //////////////////////////////////////////////////////////////////////

   hawk_cpu_stall u_hawk_cpu_stall (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .uart_boot_en_i  (uart_boot_en_i),
      .allow_access_i  (allow_access),
      .cpu_req_i       (cpu_req_i),
      .cpu_ready_o     (cpu_ready_o),
      .cpu_fwd_o       (cpu_fwd),
      .cpu_fwd_ready_i (cpu_fwd_ready)
   );

   hawk_mem_mux u_hawk_mem_mux (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .tbl_req_i       (tbl_req),
      .cpu_req_i       (cpu_fwd),
      .tbl_ready_o     (tbl_ready),
      .cpu_ready_o     (cpu_fwd_ready),
      .mem_req_o       (mem_req_o),
      .mem_ready_i     (mem_ready_i),
      .mem_rsp_i       (mem_rsp_i),
      .tbl_rsp_valid_o (tbl_rsp_valid),
      .cpu_rsp_o       (cpu_rsp_o)
   );

endmodule

//--- tb_hacd_core.sv
`timescale 1ns/1ns

module tb_hacd_core import hacd_pkg::*; ();

   localparam int unsigned TMO = 2000;              // cycles allowed per wait

   typedef struct packed {
      logic              rd;                        // read with data compare
      logic [DATA_W-1:0] data;
   } exp_rsp_t;

   typedef struct packed {
      int unsigned       due;                       // earliest cycle to answer
      logic [DATA_W-1:0] data;
   } pend_rsp_t;

   logic      clk, rst_n, uart_boot_en, sw_inactive, reg_inactive;
   logic      cpu_ready, mem_ready, init_done;
   mem_req_t  cpu_req, mem_req, prev_req;
   mem_rsp_t  cpu_rsp, mem_rsp;
   cu_state_e cu_state;

   logic [DATA_W-1:0] mem_model [logic [ADDR_W-1:0]]; // memory controller contents
   logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];   // expected contents in cpu order
   mem_req_t          fwd_q [$];                      // cpu requests owed to memory
   exp_rsp_t          rsp_q [$];                      // responses owed to cpu
   pend_rsp_t         pend_q [$];                     // memory responses in flight

   mem_req_t          fwd_head;                     // valid when an entry is present
   exp_rsp_t          rsp_head;
   logic              rsp_vld;
   logic              tbl_expect;                   // hawk enabled run
   logic              exp_tbl;                      // next transfer is a table write
   logic              hold_chk;                     // stalled request last edge
   logic [ADDR_W-1:0] exp_tbl_addr;
   logic              mem_fire;
   int unsigned       tbl_seen, cyc;
   int unsigned       err_cnt = 0;
   int unsigned       to_cnt = 0;
   int unsigned       n_req = 0;
   int unsigned       n_rsp = 0;
   int unsigned       n_xfer = 0;

   assign mem_fire = mem_req.valid & mem_ready;

   hacd_core u_hacd_core (
      .clk_i               (clk),
      .rst_n_i             (rst_n),
      .uart_boot_en_i      (uart_boot_en),
      .hawk_sw_inactive_i  (sw_inactive),
      .hawk_reg_inactive_i (reg_inactive),
      .cpu_req_i           (cpu_req),
      .cpu_ready_o         (cpu_ready),
      .cpu_rsp_o           (cpu_rsp),
      .mem_req_o           (mem_req),
      .mem_ready_i         (mem_ready),
      .mem_rsp_i           (mem_rsp),
      .init_done_o         (init_done),
      .cu_state_o          (cu_state)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                       // 40 ns period
   end

   task report_value(input string name, input logic [127:0] exp_v, input logic [127:0] act_v);
      err_cnt++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
   endtask

   task report_event(input string what);
      err_cnt++;
      $display("%0t: %s", $time, what);
   endtask

   task timed_out(input string what);
      to_cnt++;
      $display("%0t: timeout, %s", $time, what);
   endtask

   //////////////////////////////////////////////////////////////////////
   // memory controller model and expected traffic
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      logic [ADDR_W-1:0] a;
      logic [DATA_W-1:0] d;
      pend_rsp_t         p;
      hold_chk <= rst_n & mem_req.valid & ~mem_ready;
      prev_req <= mem_req;
      cyc++;
      if (!rst_n) begin
         fwd_q.delete();
         rsp_q.delete();
         pend_q.delete();
         tbl_seen = 0;
      end else begin
         if (cpu_req.valid && cpu_ready) begin     // cpu handshake
            a = uart_boot_en ? cpu_req.addr : cpu_req.addr - DRAM_BASE;
            fwd_q.push_back('{valid: 1'b1, we: cpu_req.we, addr: a, wdata: cpu_req.wdata});
            if (cpu_req.we) begin
               ref_mem[a] = cpu_req.wdata;
               rsp_q.push_back('{rd: 1'b0, data: '0}); // write ack carries no data
            end else begin
               d = ref_mem.exists(a) ? ref_mem[a] : DATA_W'(a);
               rsp_q.push_back('{rd: 1'b1, data: d});
            end
            n_req++;
         end
         if (mem_fire) begin
            if (exp_tbl) begin
               tbl_seen++;
            end else if (fwd_q.size() > 0) begin
               void'(fwd_q.pop_front());
            end
            if (mem_req.we) begin
               mem_model[mem_req.addr] = mem_req.wdata;
               d = '0;
            end else begin
               d = mem_model.exists(mem_req.addr) ? mem_model[mem_req.addr]
                                                  : DATA_W'(mem_req.addr); // unwritten
            end
            p.due  = cyc + ($urandom % 4);          // latency 1 to 4
            p.data = d;
            pend_q.push_back(p);
            n_xfer++;
         end
         if (cpu_rsp.valid) begin
            if (rsp_q.size() > 0) begin
               void'(rsp_q.pop_front());
            end
            n_rsp++;
         end
      end
   end

   always @(negedge clk) begin
      mem_ready = ($urandom % 4) != 0;              // random back-pressure
      if (rst_n && pend_q.size() > 0 && pend_q[0].due <= cyc) begin
         mem_rsp.valid = 1'b1;
         mem_rsp.rdata = pend_q[0].data;
         void'(pend_q.pop_front());
      end else begin
         mem_rsp = '0;
      end
      fwd_head     = (fwd_q.size() > 0) ? fwd_q[0] : '0;
      rsp_vld      = rsp_q.size() > 0;
      rsp_head     = rsp_vld ? rsp_q[0] : '0;
      exp_tbl      = tbl_expect && (tbl_seen < TBL_LINES);
      exp_tbl_addr = TBL_BASE + ADDR_W'(tbl_seen) * ADDR_W'(LINE_BYTES);
   end

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   a_tbl_addr: assert property (@(posedge clk) disable iff (!rst_n)
      mem_fire && exp_tbl |-> mem_req.addr == exp_tbl_addr)
      else report_value("mem_req_o.addr", $sampled(exp_tbl_addr), $sampled(mem_req.addr));
   a_tbl_zero: assert property (@(posedge clk) disable iff (!rst_n)
      mem_fire && exp_tbl |-> mem_req.we && mem_req.wdata == '0)
      else report_value("mem_req_o.{we,wdata}", {1'b1, 64'h0},
                        $sampled({mem_req.we, mem_req.wdata}));
   a_cpu_gate: assert property (@(posedge clk) disable iff (!rst_n)
      mem_fire && tbl_expect && !exp_tbl |-> init_done)
      else report_event("cpu request reached memory before init_done_o");
   a_cpu_known: assert property (@(posedge clk) disable iff (!rst_n)
      mem_fire && !exp_tbl |-> fwd_head.valid)
      else report_event("memory request with no cpu request pending");
   a_cpu_addr: assert property (@(posedge clk) disable iff (!rst_n)
      mem_fire && !exp_tbl && fwd_head.valid |-> mem_req.addr == fwd_head.addr)
      else report_value("mem_req_o.addr", $sampled(fwd_head.addr), $sampled(mem_req.addr));
   a_cpu_data: assert property (@(posedge clk) disable iff (!rst_n)
      mem_fire && !exp_tbl && fwd_head.valid |->
         mem_req.we == fwd_head.we && (!fwd_head.we || mem_req.wdata == fwd_head.wdata))
      else report_value("mem_req_o.{we,wdata}", $sampled({fwd_head.we, fwd_head.wdata}),
                        $sampled({mem_req.we, mem_req.wdata}));
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      hold_chk |-> mem_req == prev_req)
      else report_value("mem_req_o", $sampled(prev_req), $sampled(mem_req));
   a_rsp_known: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_rsp.valid |-> rsp_vld)
      else report_event("cpu response with no request outstanding");
   a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_rsp.valid && rsp_vld && rsp_head.rd |-> cpu_rsp.rdata == rsp_head.data)
      else report_value("cpu_rsp_o.rdata", $sampled(rsp_head.data), $sampled(cpu_rsp.rdata));
   a_active: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(init_done) |=> cu_state == CU_ACTIVE)
      else report_value("cu_state_o", CU_ACTIVE, $sampled(cu_state));
   a_no_init: assert property (@(posedge clk) disable iff (!rst_n)
      !tbl_expect |-> !init_done)
      else report_value("init_done_o", 1'b0, $sampled(init_done));
   a_bypass: assert property (@(posedge clk) disable iff (!rst_n)
      !tbl_expect && cu_state != CU_IDLE |-> cu_state == CU_BYPASS)
      else report_value("cu_state_o", CU_BYPASS, $sampled(cu_state));

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task apply_reset(input logic hawk_on, input logic sw, input logic regi);
      @(negedge clk);
      rst_n        = 1'b0;
      tbl_expect   = hawk_on;                       // switched while core is held
      sw_inactive  = sw;
      reg_inactive = regi;
      cpu_req      = '0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
   endtask

   // starts and ends on a falling edge
   task send_cpu(input logic we, input logic [ADDR_W-1:0] mem_addr, input logic [DATA_W-1:0] data);
      int unsigned t;
      int unsigned n0;
      n0            = n_req;
      cpu_req.valid = 1'b1;
      cpu_req.we    = we;
      cpu_req.addr  = uart_boot_en ? mem_addr : mem_addr + DRAM_BASE; // cpu view
      cpu_req.wdata = data;
      t = 0;
      do begin
         @(posedge clk);
         #1;
         t++;
      end while (n_req == n0 && t < TMO);
      if (n_req == n0) begin
         timed_out("cpu request never accepted");
      end
      @(negedge clk);
      cpu_req.valid = 1'b0;
   endtask

   task wait_state(input cu_state_e s);
      int unsigned t;
      t = 0;
      while (cu_state != s && t < TMO) begin
         @(posedge clk);
         #1;
         t++;
      end
      if (cu_state != s) begin
         timed_out("control unit never reached the expected state");
      end
      @(negedge clk);
   endtask

   task drain;
      int unsigned t;
      t = 0;
      while ((rsp_q.size() > 0 || fwd_q.size() > 0) && t < TMO) begin
         @(posedge clk);
         #1;
         t++;
      end
      if (rsp_q.size() > 0 || fwd_q.size() > 0) begin
         timed_out("cpu requests still outstanding");
      end
      @(negedge clk);
   endtask

   // writes then reads back the same lines
   task run_traffic(input int unsigned n);
      logic [ADDR_W-1:0] addrs [$];
      logic [ADDR_W-1:0] a;
      int unsigned       i;
      for (i = 0; i < n; i++) begin
         a = 40'h00_0100_0000 + ADDR_W'(($urandom % 4096) * 8); // clear of table region
         addrs.push_back(a);
         send_cpu(1'b1, a, {$urandom, $urandom});
      end
      for (i = 0; i < n; i++) begin
         send_cpu(1'b0, addrs[i], '0);
      end
      drain();
   endtask

   initial begin
      void'($urandom(32'h4862));
      rst_n        = 1'b0;
      uart_boot_en = 1'b0;
      sw_inactive  = 1'b0;
      reg_inactive = 1'b0;
      tbl_expect   = 1'b1;
      cpu_req      = '0;
      mem_ready    = 1'b0;
      mem_rsp      = '0;
      cyc          = 0;
      tbl_seen     = 0;

      // hawk enabled so the cpu is held during the table sweep
      apply_reset(1'b1, 1'b0, 1'b0);
      send_cpu(1'b0, 40'h00_0200_0040, '0);         // unwritten line
      a_early_capture: assert (cu_state == CU_INIT)
         else report_event("cpu request not captured while the table sweep ran");
      send_cpu(1'b1, 40'h00_0200_0080, 64'h0123_4567_89ab_cdef);
      wait_state(CU_ACTIVE);
      run_traffic(8);

      // software switch set so the core goes straight to bypass
      apply_reset(1'b0, 1'b1, 1'b0);
      wait_state(CU_BYPASS);
      run_traffic(8);

      // register switch set on its own
      apply_reset(1'b0, 1'b0, 1'b1);
      wait_state(CU_BYPASS);
      uart_boot_en = 1'b1;                          // no rebase from here
      run_traffic(8);

      a_count: assert (n_rsp == n_req)
         else report_value("cpu_rsp_o count", n_req, n_rsp);
      $display("errors %0d, timeouts %0d, cpu requests %0d, cpu responses %0d, transfers %0d",
               err_cnt, to_cnt, n_req, n_rsp, n_xfer);
      if (err_cnt == 0 && to_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- all.f
hacd_pkg.sv
hawk_cpu_stall.sv
hawk_ctrl_unit.sv
hawk_tbl_init.sv
hawk_mem_mux.sv
hacd_core.sv
tb_hacd_core.sv

//--- Bender.yml
package:
  name: hacd_core

sources:
  - hacd_pkg.sv
  - hawk_cpu_stall.sv
  - hawk_ctrl_unit.sv
  - hawk_tbl_init.sv
  - hawk_mem_mux.sv
  - hacd_core.sv
  - target: simulation
    files:
      - tb_hacd_core.sv
